/* project.f */
source/ingress_pkg.sv
source/sram_pkg.sv
source/port_frame_buffer.sv
source/ingress_arbiter.sv
source/write_addr_gen.sv
source/meta_fifo.sv
source/frame_readout.sv
source/ingress_fifo.sv
dv/tb_clock_gen.sv
dv/ingress_fifo_sva.sv
dv/tb_ingress_fifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_ingress_fifo \
	-f project.f \
	-o sim_ingress_fifo

./obj_dir/sim_ingress_fifo 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi

/* dv/ingress_tests.txt */
# name group port bytes
# Lines of one group start together, each on its own port
single_p0 0 0 64
single_p2 1 2 100
round_1 2 1 1
round_16 3 1 16
round_17 4 1 17
round_64 5 3 64
round_1536 6 0 1536
conc_p0 7 0 200
conc_p1 7 1 33
conc_p2 7 2 1536
conc_p3 7 3 16
wrap_a 8 3 1536
wrap_b 9 3 1536
wrap_c 10 3 1536

/* dv/tb_ingress_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench top for the shared SRAM ingress buffer
module tb_ingress_fifo;

	localparam int NUM_PORTS			= 4;
	localparam int PORT_FIFO_WORDS		= 256;
	localparam int META_DEPTH			= 16;
	localparam int PORT_BITS			= $clog2(NUM_PORTS);
	localparam int PTR_BITS				= $clog2(PORT_FIFO_WORDS);
	localparam int ADDR_BITS			= PORT_BITS + PTR_BITS;
	localparam int WORD_BYTES			= 16;
	localparam int MAX_TESTS			= 64;
	localparam int MAX_WORDS			= 4096;
	localparam int DRIVE_DELAY			= 2;
	localparam int RESET_CHECK_CYCLES	= 6;

	wire										clk_ram_ctl;
	wire										rst;

	// DUT inputs
	logic [NUM_PORTS-1:0]						port_valid;
	sram_pkg::sram_word_t [NUM_PORTS-1:0]		port_data;
	logic [NUM_PORTS-1:0]						port_last;
	ingress_pkg::last_bytes_t [NUM_PORTS-1:0]	port_last_bytes;
	logic										ram_rd_valid;
	sram_pkg::sram_word_t						ram_rd_data;

	// DUT outputs
	logic										ram_wr_en;
	logic [ADDR_BITS-1:0]						ram_wr_addr;
	sram_pkg::sram_word_t						ram_wr_data;
	logic										ram_rd_en;
	logic [ADDR_BITS-1:0]						ram_rd_addr;
	logic										frame_valid;
	logic										frame_last;
	sram_pkg::sram_word_t						frame_data;
	logic [PORT_BITS-1:0]						frame_port;
	ingress_pkg::frame_len_t					frame_bytelen;

	// Test table and generated payload
	logic [8*24-1:0]		test_name [MAX_TESTS];
	int						test_group [MAX_TESTS];
	int						test_port [MAX_TESTS];
	int						test_len [MAX_TESTS];
	int						test_words [MAX_TESTS];
	int						test_first [MAX_TESTS];
	sram_pkg::sram_word_t	word_store [MAX_WORDS];
	int						num_tests;
	int						total_words;
	logic					tests_loaded = 1'b0;
	int						seed;

	// SRAM model, reads return in order after a random latency
	sram_pkg::sram_word_t	sram_mem [2**ADDR_BITS];
	sram_pkg::sram_word_t	rd_pipe_data [$];
	int						rd_pipe_due [$];
	int						last_due = 0;
	int						cycle = 0;

	// Scoreboard
	int						exp_frames [NUM_PORTS][$];
	int						exp_wr_ptr [NUM_PORTS];
	int						words_sent [NUM_PORTS];
	int						words_written [NUM_PORTS];
	logic					in_frame = 1'b0;
	int						out_port;
	int						out_test;
	int						out_idx;
	int						frames_out = 0;
	int						errors = 0;
	int						checks = 0;

	tb_clock_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(3)
	) u_clk (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst)
	);

	ingress_fifo #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_FIFO_WORDS(PORT_FIFO_WORDS),
		.META_DEPTH(META_DEPTH)
	) uut (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.port_valid(port_valid),
		.port_data(port_data),
		.port_last(port_last),
		.port_last_bytes(port_last_bytes),
		.ram_wr_en(ram_wr_en),
		.ram_wr_addr(ram_wr_addr),
		.ram_wr_data(ram_wr_data),
		.ram_rd_en(ram_rd_en),
		.ram_rd_addr(ram_rd_addr),
		.ram_rd_valid(ram_rd_valid),
		.ram_rd_data(ram_rd_data),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_data(frame_data),
		.frame_port(frame_port),
		.frame_bytelen(frame_bytelen)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus preparation

	// Four draws fill one 128-bit word
	function automatic sram_pkg::sram_word_t random_word();
		random_word = {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic load_tests();
		int					fd;
		int					n;
		string				line;
		logic [8*24-1:0]	name;
		int					grp;
		int					port;
		int					len;
		num_tests	= 0;
		total_words	= 0;
		fd = $fopen("dv/ingress_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the test file dv/ingress_tests.txt");
			return;
		end
		while (!$feof(fd)) begin
			line	= "";
			n		= $fgets(line, fd);
			// Skip blank and comment lines
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%s %d %d %d", name, grp, port, len);
				if (n == 4 && num_tests < MAX_TESTS) begin
					test_name[num_tests]	= name;
					test_group[num_tests]	= grp;
					test_port[num_tests]	= port;
					test_len[num_tests]		= len;
					// Byte length rounded up to whole words
					test_words[num_tests]	= (len + WORD_BYTES - 1) / WORD_BYTES;
					test_first[num_tests]	= total_words;
					for (int w = 0; w < test_words[num_tests]; w++) begin
						word_store[total_words + w] = random_word();
					end
					total_words += test_words[num_tests];
					num_tests++;
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int g_start;
		int g_end;
		int max_words;
		int done_target;
		int p;
		int sva_fails;
		port_valid		= '0;
		port_data		= '0;
		port_last		= '0;
		port_last_bytes	= '0;
		ram_rd_valid	= 1'b0;
		ram_rd_data		= '0;
		seed			= 72336;
		for (int q = 0; q < NUM_PORTS; q++) begin
			exp_wr_ptr[q]		= 0;
			words_sent[q]		= 0;
			words_written[q]	= 0;
		end
		load_tests();
		tests_loaded = 1'b1;
		if (num_tests == 0) begin
			errors++;
			$display("No tests were loaded");
		end

		wait (rst === 1'b0);
		repeat (4) @(posedge clk_ram_ctl);

		g_start		= 0;
		done_target	= 0;
		while (g_start < num_tests) begin
			// Group spans consecutive lines with the same group number
			g_end = g_start;
			while (g_end + 1 < num_tests && test_group[g_end + 1] == test_group[g_start]) begin
				g_end++;
			end
			max_words = 0;
			for (int t = g_start; t <= g_end; t++) begin
				exp_frames[test_port[t]].push_back(t);
				words_sent[test_port[t]] += test_words[t];
				if (test_words[t] > max_words) begin
					max_words = test_words[t];
				end
			end
			done_target += g_end - g_start + 1;

			// All ports of the group stream side by side
			for (int w = 0; w < max_words; w++) begin
				@(posedge clk_ram_ctl);
				#DRIVE_DELAY;
				port_valid	= '0;
				port_last	= '0;
				for (int t = g_start; t <= g_end; t++) begin
					if (w < test_words[t]) begin
						p					= test_port[t];
						port_valid[p]		= 1'b1;
						port_data[p]		= word_store[test_first[t] + w];
						port_last[p]		= (w == test_words[t] - 1);
						port_last_bytes[p]	= ingress_pkg::last_bytes_t'(test_len[t]
							- WORD_BYTES * (test_words[t] - 1));
					end
				end
			end
			@(posedge clk_ram_ctl);
			#DRIVE_DELAY;
			port_valid	= '0;
			port_last	= '0;

			// Next group only once every frame of this one is out
			wait (frames_out == done_target);
			g_start = g_end + 1;
		end

		// Quiet tail catches stray output words
		repeat (20) @(posedge clk_ram_ctl);
		for (int q = 0; q < NUM_PORTS; q++) begin
			checks++;
			if (words_written[q] != words_sent[q]) begin
				errors++;
				$display("Port %0d sent %0d words but %0d reached the SRAM",
					q, words_sent[q], words_written[q]);
			end
		end
		sva_fails = uut.u_rd.u_sva.fail_count;
		$display("Checks: %0d  Errors: %0d  Assertion failures: %0d",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM read responder

	always @(posedge clk_ram_ctl) begin
		cycle = cycle + 1;
		#DRIVE_DELAY;
		if (rd_pipe_due.size() > 0 && rd_pipe_due[0] <= cycle) begin
			ram_rd_valid	= 1'b1;
			ram_rd_data		= rd_pipe_data.pop_front();
			void'(rd_pipe_due.pop_front());
		end else begin
			ram_rd_valid	= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor, sampled mid-cycle

	always @(negedge clk_ram_ctl) begin
		int lat;
		int due;
		int p;
		// Outputs quiet through reset and the first idle cycles
		if (cycle <= RESET_CHECK_CYCLES) begin
			checks++;
			if ({ram_wr_en, ram_rd_en, frame_valid, frame_last} !== 4'b0000) begin
				errors++;
				$display("Fail reset_state: expected 0000 actual %b",
					{ram_wr_en, ram_rd_en, frame_valid, frame_last});
			end
		end

		// Writes land in the sender's region at consecutive wrapping pointers
		if (ram_wr_en === 1'b1) begin
			p = int'(ram_wr_addr[ADDR_BITS-1:PTR_BITS]);
			checks++;
			if (exp_frames[p].size() == 0 || words_written[p] >= words_sent[p]) begin
				errors++;
				$display("SRAM write to %h for port %0d, which has no frame in flight",
					ram_wr_addr, p);
			end else if (ram_wr_addr[PTR_BITS-1:0] !== PTR_BITS'(exp_wr_ptr[p])) begin
				errors++;
				$display("Fail %0s: write pointer expected %h actual %h",
					test_name[exp_frames[p][0]], PTR_BITS'(exp_wr_ptr[p]),
					ram_wr_addr[PTR_BITS-1:0]);
			end
			sram_mem[ram_wr_addr]	= ram_wr_data;
			words_written[p]		= words_written[p] + 1;
			exp_wr_ptr[p]			= (exp_wr_ptr[p] + 1) % PORT_FIFO_WORDS;
		end

		// Read latency 3 to 8 cycles, kept in issue order
		if (ram_rd_en === 1'b1) begin
			lat = 3 + int'($unsigned($random(seed)) % 6);
			due = cycle + lat;
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			rd_pipe_data.push_back(sram_mem[ram_rd_addr]);
			rd_pipe_due.push_back(due);
		end

		// Output stream against the per-port expected frames
		if (frame_valid === 1'b1) begin
			if (!in_frame) begin
				p = int'(frame_port);
				if (exp_frames[p].size() == 0) begin
					errors++;
					$display("Output word on port %0d while no frame from it was pending", p);
				end else begin
					in_frame	= 1'b1;
					out_port	= p;
					out_test	= exp_frames[p][0];
					out_idx		= 0;
				end
			end
			if (in_frame) begin
				checks++;
				// Port and length stay on the sender's values for every word
				if (int'(frame_port) != test_port[out_test]) begin
					errors++;
					$display("Fail %0s: frame_port expected %0d actual %0d",
						test_name[out_test], test_port[out_test], frame_port);
				end
				if (int'(frame_bytelen) != test_len[out_test]) begin
					errors++;
					$display("Fail %0s: frame_bytelen expected %0d actual %0d",
						test_name[out_test], test_len[out_test], frame_bytelen);
				end
				if (frame_data !== word_store[test_first[out_test] + out_idx]) begin
					errors++;
					$display("Fail %0s: word %0d expected %h actual %h",
						test_name[out_test], out_idx,
						word_store[test_first[out_test] + out_idx], frame_data);
				end
				if (frame_last !== (out_idx == test_words[out_test] - 1)) begin
					errors++;
					$display("Fail %0s: frame_last at word %0d expected %b actual %b",
						test_name[out_test], out_idx,
						(out_idx == test_words[out_test] - 1), frame_last);
				end
				// Frame closes on its last word or an early frame_last
				if (frame_last === 1'b1 || out_idx == test_words[out_test] - 1) begin
					void'(exp_frames[out_port].pop_front());
					frames_out	= frames_out + 1;
					in_frame	= 1'b0;
				end else begin
					out_idx = out_idx + 1;
				end
			end
		end else if (frame_last === 1'b1) begin
			errors++;
			$display("frame_last went high without frame_valid");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Watchdog

	initial begin
		int limit;
		wait (tests_loaded === 1'b1);
		limit = total_words * 10 + 200 * num_tests;
		repeat (limit) @(posedge clk_ram_ctl);
		$display("Run hung, no result after %0d cycles", limit);
		$display("Checks: %0d  Errors: %0d", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/ingress_fifo_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// Readout FSM and metadata pop checks
module ingress_fifo_sva #(
	parameter NUM_PORTS = 4
) (
	input wire						clk_ram_ctl,
	input wire						rst,
	input wire [1:0]				state,
	input wire [NUM_PORTS-1:0]		meta_pop,
	input wire						ram_rd_en,
	input wire						frame_valid,
	input wire						frame_last
);

	// Encoding of the readout idle state
	localparam logic [1:0] IDLE_STATE = 2'd0;

	// Failure tally, read by the testbench top at the end of the run
	int fail_count = 0;

	// End of frame only on a data cycle
	a_last_has_valid: assert property (
		@(posedge clk_ram_ctl) disable iff (rst)
		frame_last |-> frame_valid
	) else begin
		fail_count++;
		$error("frame_last high without frame_valid");
	end

	// No SRAM reads while the FSM waits for metadata
	a_idle_no_read: assert property (
		@(posedge clk_ram_ctl) disable iff (rst)
		(state == IDLE_STATE) |-> !ram_rd_en
	) else begin
		fail_count++;
		$error("ram_rd_en high in the idle state");
	end

	// At most one metadata FIFO popped per cycle
	a_single_pop: assert property (
		@(posedge clk_ram_ctl) disable iff (rst)
		$onehot0(meta_pop)
	) else begin
		fail_count++;
		$error("more than one meta_pop bit set");
	end

endmodule

bind frame_readout ingress_fifo_sva #(
	.NUM_PORTS(NUM_PORTS)
) u_sva (
	.clk_ram_ctl(clk_ram_ctl),
	.rst(rst),
	.state(state),
	.meta_pop(meta_pop),
	.ram_rd_en(ram_rd_en),
	.frame_valid(frame_valid),
	.frame_last(frame_last)
);

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free running clock and power-on reset
module tb_clock_gen #(
	parameter PERIOD_NS		= 20,
	parameter RESET_CYCLES	= 3
) (
	output logic	clk_ram_ctl,
	output logic	rst
);

	initial begin
		clk_ram_ctl = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_ram_ctl = ~clk_ram_ctl;
		end
	end

	// Reset seen by RESET_CYCLES rising edges, released just after the last one
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_ram_ctl);
		#2;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* source/ingress_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Shared SRAM ingress buffer for several switch ports
module ingress_fifo #(
	parameter NUM_PORTS			= 4,
	parameter PORT_FIFO_WORDS	= 256,
	parameter META_DEPTH		= 16,
	localparam PORT_BITS		= (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
	localparam PTR_BITS			= $clog2(PORT_FIFO_WORDS),
	localparam ADDR_BITS		= PORT_BITS + PTR_BITS
) (
	input wire											clk_ram_ctl,
	input wire											rst,

	// Inbound ports
	input wire [NUM_PORTS-1:0]							port_valid,
	input wire sram_pkg::sram_word_t [NUM_PORTS-1:0]	port_data,
	input wire [NUM_PORTS-1:0]							port_last,
	input wire ingress_pkg::last_bytes_t [NUM_PORTS-1:0]	port_last_bytes,

	// SRAM
	output wire											ram_wr_en,
	output wire [ADDR_BITS-1:0]							ram_wr_addr,
	output wire sram_pkg::sram_word_t					ram_wr_data,
	output wire											ram_rd_en,
	output wire [ADDR_BITS-1:0]							ram_rd_addr,
	input wire											ram_rd_valid,
	input wire sram_pkg::sram_word_t					ram_rd_data,

	// Outbound frame stream
	output wire											frame_valid,
	output wire											frame_last,
	output wire sram_pkg::sram_word_t					frame_data,
	output wire [PORT_BITS-1:0]							frame_port,
	output wire ingress_pkg::frame_len_t				frame_bytelen
);

	wire [NUM_PORTS-1:0]						frame_ready;
	wire [NUM_PORTS-1:0]						frame_start;
	wire [NUM_PORTS-1:0]						word_valid;
	wire [NUM_PORTS-1:0]						frame_done;
	wire sram_pkg::sram_word_t [NUM_PORTS-1:0]	word_data;
	wire ingress_pkg::frame_len_t [NUM_PORTS-1:0]	frame_len;
	wire [NUM_PORTS-1:0]						meta_empty;
	wire [NUM_PORTS-1:0]						meta_pop;
	wire ingress_pkg::frame_len_t [NUM_PORTS-1:0]	meta_len;
	wire										wr_valid;
	wire [PORT_BITS-1:0]						wr_port;
	wire sram_pkg::sram_word_t					wr_data;

	// One frame buffer and one length FIFO per port
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
		port_frame_buffer u_buf (
			.clk_ram_ctl(clk_ram_ctl),
			.rst(rst),
			.port_valid(port_valid[g]),
			.port_data(port_data[g]),
			.port_last(port_last[g]),
			.port_last_bytes(port_last_bytes[g]),
			.frame_ready(frame_ready[g]),
			.frame_start(frame_start[g]),
			.word_valid(word_valid[g]),
			.word_data(word_data[g]),
			.frame_done(frame_done[g]),
			.frame_len(frame_len[g])
		);

		// Length is pushed as the last word leaves, two cycles before it lands in SRAM
		meta_fifo #(
			.META_DEPTH(META_DEPTH)
		) u_meta (
			.clk_ram_ctl(clk_ram_ctl),
			.rst(rst),
			.push(frame_done[g]),
			.len_in(frame_len[g]),
			.pop(meta_pop[g]),
			.len_out(meta_len[g]),
			.empty(meta_empty[g])
		);
	end

	ingress_arbiter #(
		.NUM_PORTS(NUM_PORTS)
	) u_arb (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.frame_ready(frame_ready),
		.frame_done(frame_done),
		.word_valid(word_valid),
		.word_data(word_data),
		.frame_start(frame_start),
		.wr_valid(wr_valid),
		.wr_port(wr_port),
		.wr_data(wr_data)
	);

	write_addr_gen #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_FIFO_WORDS(PORT_FIFO_WORDS)
	) u_wr (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.wr_valid(wr_valid),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.ram_wr_en(ram_wr_en),
		.ram_wr_addr(ram_wr_addr),
		.ram_wr_data(ram_wr_data)
	);

	frame_readout #(
		.NUM_PORTS(NUM_PORTS),
		.PORT_FIFO_WORDS(PORT_FIFO_WORDS)
	) u_rd (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.meta_empty(meta_empty),
		.meta_len(meta_len),
		.meta_pop(meta_pop),
		.ram_rd_en(ram_rd_en),
		.ram_rd_addr(ram_rd_addr),
		.ram_rd_valid(ram_rd_valid),
		.ram_rd_data(ram_rd_data),
		.frame_valid(frame_valid),
		.frame_last(frame_last),
		.frame_data(frame_data),
		.frame_port(frame_port),
		.frame_bytelen(frame_bytelen)
	);

endmodule

`default_nettype wire

/* source/frame_readout.sv */
`timescale 1ns/1ps
`default_nettype none

// Reads stored frames back from SRAM one at a time and forms the output stream
module frame_readout #(
	parameter NUM_PORTS			= 4,
	parameter PORT_FIFO_WORDS	= 256,
	localparam PORT_BITS		= (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
	localparam PTR_BITS			= $clog2(PORT_FIFO_WORDS),
	localparam ADDR_BITS		= PORT_BITS + PTR_BITS,
	localparam LOW_BITS			= $clog2(ingress_pkg::WORD_BYTES)
) (
	input wire										clk_ram_ctl,
	input wire										rst,

	// Metadata FIFOs
	input wire [NUM_PORTS-1:0]						meta_empty,
	input wire ingress_pkg::frame_len_t [NUM_PORTS-1:0]	meta_len,
	output logic [NUM_PORTS-1:0]					meta_pop,

	// SRAM read port
	output logic									ram_rd_en,
	output logic [ADDR_BITS-1:0]					ram_rd_addr,
	input wire										ram_rd_valid,
	input wire sram_pkg::sram_word_t				ram_rd_data,

	// Outbound frame stream
	output logic									frame_valid,
	output logic									frame_last,
	output sram_pkg::sram_word_t					frame_data,
	output logic [PORT_BITS-1:0]					frame_port,
	output ingress_pkg::frame_len_t					frame_bytelen
);

	typedef enum logic [1:0] {
		ST_IDLE,	// waiting for a non-empty metadata FIFO
		ST_META,	// pop issued, waiting for the length
		ST_FETCH,	// issuing one SRAM read per cycle
		ST_DRAIN	// all reads out, counting returns
	} state_t;

	state_t						state;
	logic [PORT_BITS-1:0]		rr_port;
	logic [PORT_BITS-1:0]		pick_port;
	logic						pick_valid;
	logic [PORT_BITS-1:0]		cur_port;
	logic						len_valid;
	logic [PTR_BITS-1:0]		rd_ptr [NUM_PORTS];
	ingress_pkg::word_count_t	meta_words;
	ingress_pkg::word_count_t	cur_words;
	ingress_pkg::word_count_t	issued;
	ingress_pkg::word_count_t	returned;
	logic						issue_rd;
	logic						rx_final;

	// Round robin among ports with stored frames, starting at rr_port
	always_comb begin
		int unsigned idx;
		pick_valid	= 1'b0;
		pick_port	= rr_port;
		for (int unsigned i = 0; i < NUM_PORTS; i++) begin
			idx = (rr_port + i) % NUM_PORTS;
			if (!pick_valid && !meta_empty[idx]) begin
				pick_valid	= 1'b1;
				pick_port	= PORT_BITS'(idx);
			end
		end
	end

	// Byte length rounded up to whole words
	assign meta_words = ingress_pkg::word_count_t'(meta_len[cur_port] >> LOW_BITS)
		+ ingress_pkg::word_count_t'(|meta_len[cur_port][LOW_BITS-1:0]);

	// First read goes out as soon as the length arrives
	assign issue_rd	= ((state == ST_META) && len_valid) || (state == ST_FETCH);
	assign rx_final	= ram_rd_valid && (returned == cur_words - 1'b1);

	////////////////////////////////////////////////////////////////////////////
	// Readout FSM

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			state		<= ST_IDLE;
			rr_port		<= '0;
			cur_port	<= '0;
			meta_pop	<= '0;
			len_valid	<= 1'b0;
			ram_rd_en	<= 1'b0;
			frame_valid	<= 1'b0;
			frame_last	<= 1'b0;
			cur_words	<= '0;
			issued		<= '0;
			returned	<= '0;
			for (int i = 0; i < NUM_PORTS; i++) begin
				rd_ptr[i] <= '0;
			end
		end else begin
			meta_pop	<= '0;
			len_valid	<= |meta_pop;
			ram_rd_en	<= issue_rd;
			frame_valid	<= ram_rd_valid;
			frame_last	<= rx_final;

			if (issue_rd) begin
				rd_ptr[cur_port] <= rd_ptr[cur_port] + 1'b1;
			end
			if (ram_rd_valid) begin
				returned <= returned + 1'b1;
			end

			case (state)
				ST_IDLE: begin
					if (pick_valid) begin
						meta_pop[pick_port]	<= 1'b1;
						cur_port			<= pick_port;
						rr_port	<= (pick_port == PORT_BITS'(NUM_PORTS - 1)) ? '0 : pick_port + 1'b1;
						state				<= ST_META;
					end
				end
				ST_META: begin
					if (len_valid) begin
						cur_words	<= meta_words;
						issued		<= 7'd1;
						returned	<= '0;
						state		<= (meta_words == 7'd1) ? ST_DRAIN : ST_FETCH;
					end
				end
				ST_FETCH: begin
					issued <= issued + 1'b1;
					if (issued == cur_words - 1'b1) begin
						state <= ST_DRAIN;
					end
				end
				default: begin
					if (rx_final) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address and output payload

	always_ff @(posedge clk_ram_ctl) begin
		if (issue_rd) begin
			ram_rd_addr <= {cur_port, rd_ptr[cur_port]};
		end
		if (ram_rd_valid) begin
			frame_data <= ram_rd_data;
		end

		// Held until the next frame's length comes in
		if ((state == ST_META) && len_valid) begin
			frame_port		<= cur_port;
			frame_bytelen	<= meta_len[cur_port];
		end
	end

endmodule

`default_nettype wire

/* source/meta_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Frame length FIFO for one port
// META_DEPTH must be a power of two, pointers wrap on their own
module meta_fifo #(
	parameter META_DEPTH	= 16,
	localparam PTR_BITS		= (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1
) (
	input wire							clk_ram_ctl,
	input wire							rst,

	input wire							push,
	input wire ingress_pkg::frame_len_t	len_in,

	input wire							pop,
	output ingress_pkg::frame_len_t		len_out,
	output logic						empty
);

	ingress_pkg::frame_len_t	len_mem [META_DEPTH];
	logic [PTR_BITS-1:0]		wr_ptr;
	logic [PTR_BITS-1:0]		rd_ptr;

	// Storage, read data one cycle after pop
	always_ff @(posedge clk_ram_ctl) begin
		if (push) begin
			len_mem[wr_ptr] <= len_in;
		end
		if (pop) begin
			len_out <= len_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			empty	<= 1'b1;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// Flag lags the pointers by a cycle to keep it off the compare path
			// Readout spends several cycles per frame so the lag is harmless
			// No full detection, a full FIFO reads as empty
			empty <= (wr_ptr == rd_ptr);
		end
	end

endmodule

`default_nettype wire

/* source/write_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Per-port wrapping write pointers and the registered SRAM write port
module write_addr_gen #(
	parameter NUM_PORTS			= 4,
	parameter PORT_FIFO_WORDS	= 256,
	localparam PORT_BITS		= (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
	localparam PTR_BITS			= $clog2(PORT_FIFO_WORDS),
	localparam ADDR_BITS		= PORT_BITS + PTR_BITS
) (
	input wire						clk_ram_ctl,
	input wire						rst,

	input wire						wr_valid,
	input wire [PORT_BITS-1:0]		wr_port,
	input wire sram_pkg::sram_word_t	wr_data,

	output logic					ram_wr_en,
	output logic [ADDR_BITS-1:0]	ram_wr_addr,
	output sram_pkg::sram_word_t	ram_wr_data
);

	// Pointer wraps inside the port's own region
	logic [PTR_BITS-1:0]	wr_ptr [NUM_PORTS];

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			ram_wr_en <= 1'b0;
			for (int i = 0; i < NUM_PORTS; i++) begin
				wr_ptr[i] <= '0;
			end
		end else begin
			ram_wr_en <= wr_valid;
			if (wr_valid) begin
				wr_ptr[wr_port] <= wr_ptr[wr_port] + 1'b1;
			end
		end
	end

	// Port number in the high address bits selects the region
	always_ff @(posedge clk_ram_ctl) begin
		if (wr_valid) begin
			ram_wr_addr	<= {wr_port, wr_ptr[wr_port]};
			ram_wr_data	<= wr_data;
		end
	end

endmodule

`default_nettype wire

/* source/ingress_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// Grants the SRAM write side to one port buffer at a time
module ingress_arbiter #(
	parameter NUM_PORTS = 4,
	localparam PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
	input wire									clk_ram_ctl,
	input wire									rst,

	input wire [NUM_PORTS-1:0]					frame_ready,
	input wire [NUM_PORTS-1:0]					frame_done,
	input wire [NUM_PORTS-1:0]					word_valid,
	input wire sram_pkg::sram_word_t [NUM_PORTS-1:0]	word_data,

	output logic [NUM_PORTS-1:0]				frame_start,

	// Registered word toward the address generator
	output logic								wr_valid,
	output logic [PORT_BITS-1:0]				wr_port,
	output sram_pkg::sram_word_t				wr_data
);

	logic [PORT_BITS-1:0]	rr_port;
	logic [PORT_BITS-1:0]	cur_port;
	logic [PORT_BITS-1:0]	next_port;
	logic					next_valid;
	logic					busy;
	logic					start;

	// Round robin port first, else highest numbered ready port
	always_comb begin
		next_port	= rr_port;
		next_valid	= frame_ready[rr_port];
		if (!next_valid) begin
			for (int i = NUM_PORTS - 1; i >= 0; i--) begin
				if (!next_valid && frame_ready[i]) begin
					next_port	= PORT_BITS'(i);
					next_valid	= 1'b1;
				end
			end
		end
	end

	// Start while idle or on the last word, frames go back to back
	always_comb begin
		start					= next_valid && (!busy || frame_done[cur_port]);
		frame_start				= '0;
		frame_start[next_port]	= start;
	end

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			rr_port		<= '0;
			cur_port	<= '0;
			busy		<= 1'b0;
			wr_valid	<= 1'b0;
		end else begin
			if (start) begin
				busy		<= 1'b1;
				cur_port	<= next_port;
				rr_port		<= (rr_port == PORT_BITS'(NUM_PORTS - 1)) ? '0 : rr_port + 1'b1;
			end else if (frame_done[cur_port]) begin
				busy		<= 1'b0;
			end

			// Replay begins the cycle after start, cur_port already follows it
			wr_valid	<= word_valid[cur_port];
		end
	end

	always_ff @(posedge clk_ram_ctl) begin
		wr_port	<= cur_port;
		wr_data	<= word_data[cur_port];
	end

endmodule

`default_nettype wire

/* source/port_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// Holds one whole frame from a switch port, replays it once granted
module port_frame_buffer (
	input wire							clk_ram_ctl,
	input wire							rst,

	// Word stream from the port, no back-pressure
	input wire							port_valid,
	input wire sram_pkg::sram_word_t	port_data,
	input wire							port_last,
	input wire ingress_pkg::last_bytes_t	port_last_bytes,

	// Replay toward the write arbiter
	output logic						frame_ready,
	input wire							frame_start,
	output logic						word_valid,
	output sram_pkg::sram_word_t		word_data,
	output logic						frame_done,
	output ingress_pkg::frame_len_t		frame_len
);

	sram_pkg::sram_word_t		frame_mem [ingress_pkg::MAX_FRAME_WORDS];
	ingress_pkg::word_count_t	wr_count;
	ingress_pkg::word_count_t	frame_words;
	ingress_pkg::word_count_t	rd_ptr;
	logic						rd_busy;
	logic						issue;
	ingress_pkg::word_count_t	issue_ptr;
	logic						issue_last;

	// The start pulse itself reads word 0 so data follows one cycle later
	assign issue		= frame_start || rd_busy;
	assign issue_ptr	= frame_start ? '0 : rd_ptr;
	assign issue_last	= (issue_ptr == frame_words - 1'b1);

	////////////////////////////////////////////////////////////////////////////
	// Frame storage and replay data

	always_ff @(posedge clk_ram_ctl) begin
		if (port_valid) begin
			frame_mem[wr_count] <= port_data;
		end

		// Byte length is full words so far plus the partial last word
		if (port_valid && port_last) begin
			frame_words	<= wr_count + 1'b1;
			frame_len	<= ingress_pkg::frame_len_t'(wr_count * ingress_pkg::WORD_BYTES)
				+ ingress_pkg::frame_len_t'(port_last_bytes);
		end

		if (issue) begin
			word_data <= frame_mem[issue_ptr];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			wr_count	<= '0;
			frame_ready	<= 1'b0;
			rd_busy		<= 1'b0;
			rd_ptr		<= '0;
			word_valid	<= 1'b0;
			frame_done	<= 1'b0;
		end else begin
			word_valid	<= issue;
			frame_done	<= issue && issue_last;

			// Word counter restarts for the next frame
			if (port_valid) begin
				wr_count <= port_last ? '0 : wr_count + 1'b1;
			end

			// Ready from end of capture until the arbiter grants us
			if (port_valid && port_last) begin
				frame_ready <= 1'b1;
			end else if (frame_start) begin
				frame_ready <= 1'b0;
			end

			if (issue) begin
				rd_ptr	<= issue_ptr + 1'b1;
				rd_busy	<= !issue_last;
			end
		end
	end

endmodule

`default_nettype wire

/* source/sram_pkg.sv */
`default_nettype none

// External SRAM data word as seen by the write and read sides
package sram_pkg;

	// Full data width of one SRAM location
	// No ECC lanes, every bit carries frame payload
	localparam int SRAM_WORD_BITS = 128;

	// One SRAM word, byte 0 of the frame word sits in the top byte lane
	typedef logic [SRAM_WORD_BITS-1:0] sram_word_t;

endpackage

`default_nettype wire

/* source/ingress_pkg.sv */
`default_nettype none

// Frame level definitions shared by the port buffers, metadata FIFOs and readout
package ingress_pkg;

	// Largest frame a port may deliver, in bytes
	localparam int MAX_FRAME_BYTES = 1536;

	// Bytes carried by one data word
	localparam int WORD_BYTES = 16;

	// Words needed for the largest frame
	localparam int MAX_FRAME_WORDS = MAX_FRAME_BYTES / WORD_BYTES;

	// Byte length of a frame, 0 to MAX_FRAME_BYTES
	typedef logic [$clog2(MAX_FRAME_BYTES + 1)-1:0] frame_len_t;

	// Number of words in a frame
	typedef logic [$clog2(MAX_FRAME_WORDS + 1)-1:0] word_count_t;

	// Valid bytes in the last word of a frame, 1 to WORD_BYTES
	typedef logic [$clog2(WORD_BYTES + 1)-1:0] last_bytes_t;

endpackage

`default_nettype wire
